//--- run_sim.sh
#!/bin/sh
# build and run the loader testbench with Verilator
# the log is searched for the fail message to decide the result

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module bubble_loader_tb \
    -o bubble_loader_sim \
    && ./obj_dir/bubble_loader_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
    && { echo "testbench reported failure"; exit 1; } \
    || grep -q "Simulation finished: PASS" sim.log \
    || { echo "no result line in log"; exit 1; }

//--- sources.f
verilog/bubble_pkg.sv
verilog/position_page_converter.sv
verilog/loop_map_table.sv
verilog/spi_flash_reader.sv
verilog/spi_loader_ctrl.sv
verilog/bubble_loader_top.sv
tb/bubble_loader_props.sv
tb/bubble_loader_tb.sv

//--- tb/bubble_loader_props.sv
`default_nettype none
`timescale 1ns/1ns

module bubble_loader_props
(
    input  wire                        MCLK,
    input  wire                        rst_n,
    input  var bubble_pkg::flash_spi_t flash,
    input  var bubble_pkg::buf_wr_t    buf_wr
);
    import bubble_pkg::*;

    // sck only toggles inside a selected transfer
    sck_inside_cs: assert property (
        @(posedge MCLK) disable iff (!rst_n)
        !flash.sck |-> !flash.cs_n
    ) else $error("sck low while cs_n is high");

    // buffer strobes are single cycle
    strobe_single: assert property (
        @(posedge MCLK) disable iff (!rst_n)
        buf_wr.strobe |=> !buf_wr.strobe
    ) else $error("buffer strobe held for two cycles");

    // flash deselected right out of reset
    cs_high_after_reset: assert property (
        @(posedge MCLK)
        $rose(rst_n) |-> flash.cs_n
    ) else $error("cs_n low in the first cycle after reset");

endmodule

bind bubble_loader_top bubble_loader_props props_i
(
    .MCLK   (MCLK),
    .rst_n  (rst_n),
    .flash  (flash),
    .buf_wr (buf_wr)
);

`default_nettype wire

//--- tb/bubble_loader_tb.sv
`default_nettype none
`timescale 1ns/1ns

module bubble_loader_tb;
    import bubble_pkg::*;

    localparam int BOOT_B = 16;
    localparam int MAP_B  = 48;
    localparam int PAGE_B = 24;
    localparam int LOADS  = 8;
    localparam int LIMIT  = 4 * (((BOOT_B + MAP_B) + 7 * MAP_B) * 2 + LOADS * 64);

    logic       MCLK;
    logic       rst_n;
    logic [2:0] img_num;
    acc_type_e  acc_type;
    logic [11:0] abs_pos;
    logic       miso;
    flash_spi_t flash;
    buf_wr_t    buf_wr;

    logic        page_mem [0:4095];   // flash contents of data pages
    logic        boot_mem [0:511];    // 64 boot bits per image
    logic        map_model [0:4095];
    logic [15:0] exp_q [$];           // {addr, data} in write order
    logic [31:0] exp_instr_q [$];
    logic [31:0] cap_q [$];           // instructions seen by the flash model
    logic [31:0] rx_instr;
    int          bit_cnt;
    int          cycles;
    int          errors;
    int          tests;
    int          failed;

    bubble_loader_top #(
        .BOOT_BITS (BOOT_B),
        .MAP_BITS  (MAP_B),
        .PAGE_BITS (PAGE_B)
    ) dut_i (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .img_num  (img_num),
        .acc_type (acc_type),
        .abs_pos  (abs_pos),
        .miso     (miso),
        .flash    (flash),
        .buf_wr   (buf_wr)
    );

    always #20 MCLK = ~MCLK;

    function automatic logic flash_bit(input logic [23:0] addr, input int idx);
        int pg;
        int im;
        pg = int'(addr[18:7]);
        im = int'(addr[21:19]);
        if (addr[18:7] == BOOT_PAGE)
            return boot_mem[im * 64 + idx];
        return page_mem[(pg * 37 + im * 101 + idx) % 4096];
    endfunction

    // flash model takes the address on rising sck and returns data on falling sck
    always @(posedge flash.sck)
    begin
        if (!flash.cs_n)
        begin
            if (bit_cnt < 32)
                rx_instr = {rx_instr[30:0], flash.mosi};
            if (bit_cnt == 31)
                cap_q.push_back(rx_instr);
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge flash.sck)
    begin
        if (!flash.cs_n && bit_cnt >= 32)
            miso <= flash_bit(rx_instr[23:0], bit_cnt - 32);
    end

    always @(posedge flash.cs_n)
        bit_cnt = 0;

    // compare every buffer strobe against the expected run
    always @(negedge MCLK)
    begin
        logic [15:0] e;
        if (rst_n && buf_wr.strobe)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("unexpected buffer write to address %0d at %0t ns",
                         buf_wr.addr, $time);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                assert (buf_wr.addr == e[15:1] && buf_wr.data == e[0])
                else
                begin
                    $display("** Error %0t ns: write addr %0d data %0b, expected addr %0d data %0b",
                             $time, buf_wr.addr, buf_wr.data, e[15:1], e[0]);
                    errors++;
                end
            end
        end
    end

    always @(posedge MCLK)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic expect_boot(input logic [2:0] img);
        int j;
        int loc;
        logic [23:0] a;
        logic b;
        a = {2'b00, img, BOOT_PAGE, 7'd0};
        exp_instr_q.push_back({READ_CMD, a});
        for (int i = 0; i < BOOT_B; i++)
            exp_q.push_back({BOOT_BASE + 15'(i), flash_bit(a, i)});
        for (j = 0; j < MAP_B; j++)
        begin
            b = flash_bit(a, BOOT_B + j);
            exp_q.push_back({BOOT_BASE + 15'(BOOT_B + j), b});
            loc = (j & ~15) | (15 - (j & 15));   // loop order reversed per nibble
            map_model[loc] = b;
        end
    endtask

    task automatic expect_page(input logic [2:0] img, input int pos);
        int pg;
        int good;
        int k;
        int m;
        logic [23:0] a;
        pg = (pos + 1) % PAGE_COUNT;
        a = {2'b00, img, 12'(pg), 7'd0};
        exp_instr_q.push_back({READ_CMD, a});
        good = 0;
        k = 0;
        m = 0;
        while (good < LEAD_BITS + PAGE_B && m < 4096)
        begin
            if (!map_model[m])
                exp_q.push_back({PAGE_BASE + 15'(m), 1'b0});   // bad loop
            else if (good < LEAD_BITS)
            begin
                exp_q.push_back({PAGE_BASE + 15'(m), 1'b1});
                good++;
            end
            else
            begin
                exp_q.push_back({PAGE_BASE + 15'(m), flash_bit(a, k)});
                k++;
                good++;
            end
            m++;
        end
    endtask

    task automatic wait_cs(input logic level);
        while (flash.cs_n != level)
            @(negedge MCLK);
    endtask

    task automatic run_load(input acc_type_e acc, input logic [2:0] img, input int pos);
        @(negedge MCLK);
        img_num  = img;
        abs_pos  = 12'(pos);
        acc_type = acc;
        wait_cs(1'b0);
        @(negedge MCLK);
        acc_type = ACC_IDLE;
        wait_cs(1'b1);
        repeat (2) @(negedge MCLK);
    endtask

    task automatic check_load_end();
        logic [31:0] exp_i;
        logic [31:0] got_i;
        assert (exp_q.size() == 0)
        else
        begin
            $display("load ended with %0d buffer writes missing", exp_q.size());
            errors++;
            exp_q.delete();
        end
        while (exp_instr_q.size() != 0)
        begin
            exp_i = exp_instr_q.pop_front();
            assert (cap_q.size() != 0)
            else
            begin
                $display("flash saw no read instruction for this load");
                errors++;
            end
            if (cap_q.size() != 0)
            begin
                got_i = cap_q.pop_front();
                assert (got_i == exp_i)
                else
                begin
                    $display("** Error %0t ns: instruction %h, expected %h",
                             $time, got_i, exp_i);
                    errors++;
                end
            end
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        if (errors != err_before)
            failed++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial
    begin
        int e0;
        int zeros;
        int pos;
        logic b;
        MCLK     = 1'b0;
        rst_n    = 1'b0;
        img_num  = '0;
        acc_type = ACC_IDLE;
        abs_pos  = '0;
        miso     = 1'b0;
        rx_instr = '0;
        bit_cnt  = 0;
        cycles   = 0;
        errors   = 0;
        tests    = 0;
        failed   = 0;
        void'($urandom(90));
        for (int i = 0; i < 4096; i++)
        begin
            page_mem[i]  = 1'($urandom % 2);
            map_model[i] = 1'b0;
        end
        for (int im = 0; im < 8; im++)
        begin
            zeros = 0;
            for (int i = 0; i < 64; i++)
            begin
                b = 1'($urandom % 2);
                if (i >= BOOT_B)
                begin
                    b = ($urandom % 4) != 0;   // map bits mostly good
                    if (!b && zeros >= 12)
                        b = 1'b1;              // keeps at least 36 good loops
                    else if (!b)
                        zeros++;
                end
                boot_mem[im * 64 + i] = b;
            end
        end
        repeat (3) @(negedge MCLK);
        rst_n = 1'b1;

        e0 = errors;
        repeat (10)
        begin
            @(negedge MCLK);
            assert (flash.cs_n && flash.sck && !buf_wr.strobe)
            else
            begin
                $display("** Error %0t ns: bus not idle after reset", $time);
                errors++;
            end
        end
        report("reset idle", e0);

        e0 = errors;
        expect_boot(3'd2);
        run_load(ACC_BOOT, 3'd2, 0);
        check_load_end();
        report("boot load", e0);

        for (int t = 0; t < 5; t++)
        begin
            e0 = errors;
            if (t == 0)
                pos = 2052;
            else if (t == 1)
                pos = 4095;
            else
                pos = int'($urandom % 4096);
            expect_page(3'(t + 1), pos);
            run_load(ACC_PAGE, 3'(t + 1), pos);
            check_load_end();
            report($sformatf("page load pos %0d", pos), e0);
        end

        // acc_type stays non-idle across two loads
        e0 = errors;
        pos = int'($urandom % 4096);
        expect_page(3'd1, pos);
        expect_page(3'd6, pos);
        @(negedge MCLK);
        img_num  = 3'd1;
        abs_pos  = 12'(pos);
        acc_type = ACC_PAGE;
        wait_cs(1'b0);
        @(negedge MCLK);
        img_num = 3'd6;
        wait_cs(1'b1);
        wait_cs(1'b0);
        @(negedge MCLK);
        acc_type = ACC_IDLE;
        wait_cs(1'b1);
        repeat (2) @(negedge MCLK);
        check_load_end();
        report("back to back", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bubble_loader_top.sv
`default_nettype none
`timescale 1ns/1ns

module bubble_loader_top
#(
    parameter int BOOT_BITS = 2656,
    parameter int MAP_BITS  = 1168,
    parameter int PAGE_BITS = 512
)
(
    input  wire                       MCLK,
    input  wire                       rst_n,
    input  wire  [2:0]                img_num,
    input  var bubble_pkg::acc_type_e acc_type,
    input  wire  [11:0]               abs_pos,
    input  wire                       miso,
    output bubble_pkg::flash_spi_t    flash,
    output bubble_pkg::buf_wr_t       buf_wr
);
    import bubble_pkg::*;

    logic        conv_start;
    logic [11:0] page;
    spi_op_e     spi_op;
    logic        cs_sel;
    logic [11:0] flash_page;
    logic        bit_data;
    logic        op_done;
    logic        map_wr;
    logic [11:0] map_waddr;
    logic        map_wdata;
    logic        map_rd;
    logic [11:0] map_raddr;
    logic        map_rdata;

    spi_loader_ctrl #(
        .BOOT_BITS (BOOT_BITS),
        .MAP_BITS  (MAP_BITS),
        .PAGE_BITS (PAGE_BITS)
    ) ctrl_i (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .acc_type   (acc_type),
        .page       (page),
        .bit_data   (bit_data),
        .op_done    (op_done),
        .map_rdata  (map_rdata),
        .conv_start (conv_start),
        .spi_op     (spi_op),
        .cs_sel     (cs_sel),
        .flash_page (flash_page),
        .map_wr     (map_wr),
        .map_waddr  (map_waddr),
        .map_wdata  (map_wdata),
        .map_rd     (map_rd),
        .map_raddr  (map_raddr),
        .buf_wr     (buf_wr)
    );

    position_page_converter conv_i (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .conv_start (conv_start),
        .abs_pos    (abs_pos),
        .page       (page)
    );

    loop_map_table map_i (
        .MCLK      (MCLK),
        .map_wr    (map_wr),
        .map_waddr (map_waddr),
        .map_wdata (map_wdata),
        .map_rd    (map_rd),
        .map_raddr (map_raddr),
        .map_rdata (map_rdata)
    );

    spi_flash_reader spi_i (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .spi_op     (spi_op),
        .cs_sel     (cs_sel),
        .img_num    (img_num),
        .flash_page (flash_page),
        .miso       (miso),
        .flash      (flash),
        .bit_data   (bit_data),
        .op_done    (op_done)
    );

endmodule

`default_nettype wire

//--- verilog/bubble_pkg.sv
`default_nettype none

package bubble_pkg;

    // access type reported by the emulator core
    typedef enum logic [1:0] {
        ACC_IDLE = 2'd0,
        ACC_BOOT = 2'd1,
        ACC_PAGE = 2'd2
    } acc_type_e;

    // one command from the controller to the SPI shifter
    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_LOAD   = 2'd1,   // load instruction register
        OP_SHIFT  = 2'd2,   // send one instruction bit
        OP_SAMPLE = 2'd3    // read one data bit
    } spi_op_e;

    typedef struct packed {
        logic cs_n;
        logic sck;
        logic mosi;
    } flash_spi_t;

    typedef struct packed {
        logic        strobe;
        logic [14:0] addr;
        logic        data;
    } buf_wr_t;

    localparam logic [11:0] BOOT_PAGE  = 12'h805;   // bootloader block
    localparam int          PAGE_COUNT = 2053;      // data pages per image
    localparam logic [14:0] BOOT_BASE  = 15'd2053;  // first bootloader bit in buffer
    localparam logic [14:0] PAGE_BASE  = 15'd7168;  // first page bit in buffer
    localparam int          LEAD_BITS  = 6;         // good loops forced to 1
    localparam logic [7:0]  READ_CMD   = 8'h03;     // standard read

endpackage

`default_nettype wire

//--- verilog/loop_map_table.sv
`default_nettype none
`timescale 1ns/1ns

module loop_map_table
(
    input  wire         MCLK,
    input  wire         map_wr,
    input  wire  [11:0] map_waddr,
    input  wire         map_wdata,
    input  wire         map_rd,
    input  wire  [11:0] map_raddr,
    output logic        map_rdata
);

    logic        map_mem [0:4095];   // 1 = good loop, 0 = bad loop
    logic [11:0] wr_loc;

    // the device numbers loops backwards inside each group of 16,
    // so the flash order is flipped on the way in and reads stay linear
    assign wr_loc = {map_waddr[11:4], ~map_waddr[3:0]};

    always_ff @(posedge MCLK)
    begin
        if (map_wr)
        begin
            map_mem[wr_loc] <= map_wdata;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (map_rd)
        begin
            map_rdata <= map_mem[map_raddr];   // valid the cycle after map_rd
        end
    end

endmodule

`default_nettype wire

//--- verilog/position_page_converter.sv
`default_nettype none
`timescale 1ns/1ns

module position_page_converter
(
    input  wire         MCLK,
    input  wire         rst_n,
    input  wire         conv_start,
    input  wire  [11:0] abs_pos,
    output logic [11:0] page
);
    import bubble_pkg::*;

    localparam logic [12:0] MODULUS = 13'(PAGE_COUNT);

    logic [12:0] next_pos;   // one wider so 4095 + 1 does not wrap
    logic [12:0] wrapped;

    // the core has already advanced its position when the load runs
    assign next_pos = {1'b0, abs_pos} + 13'd1;
    assign wrapped  = next_pos - MODULUS;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            page <= '0;
        end
        else if (conv_start)
        begin
            if (next_pos >= MODULUS)
                page <= wrapped[11:0];   // a single reduction covers 0..4096
            else
                page <= next_pos[11:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/spi_flash_reader.sv
`default_nettype none
`timescale 1ns/1ns

module spi_flash_reader
(
    input  wire                     MCLK,
    input  wire                     rst_n,
    input  var bubble_pkg::spi_op_e spi_op,
    input  wire                     cs_sel,
    input  wire  [2:0]              img_num,
    input  wire  [11:0]             flash_page,
    input  wire                     miso,
    output bubble_pkg::flash_spi_t  flash,
    output logic                    bit_data,
    output logic                    op_done
);
    import bubble_pkg::*;

    logic [32:0] instr_sr;      // dummy msb + opcode + 24 bit address
    logic        cs_n_q;
    logic        sck_q;
    logic        low_phase;     // sck is low, rising edge comes next
    logic        sample_pend;   // current op reads miso
    logic        start_op;

    assign start_op = (spi_op == OP_SHIFT || spi_op == OP_SAMPLE) && !low_phase;

    assign flash = '{cs_n: cs_n_q, sck: sck_q, mosi: instr_sr[32]};

    // two-phase sequencer with sck idling high
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            cs_n_q      <= 1'b1;
            sck_q       <= 1'b1;
            low_phase   <= 1'b0;
            sample_pend <= 1'b0;
            op_done     <= 1'b0;
        end
        else
        begin
            cs_n_q  <= ~cs_sel;
            op_done <= 1'b0;
            if (low_phase)
            begin
                sck_q     <= 1'b1;   // flash latches mosi here
                low_phase <= 1'b0;
                op_done   <= 1'b1;
            end
            else if (start_op)
            begin
                sck_q       <= 1'b0;
                low_phase   <= 1'b1;
                sample_pend <= (spi_op == OP_SAMPLE);
            end
        end
    end

    // address laid out as 00 iii pppppppppppp 0000000
    always_ff @(posedge MCLK)
    begin
        if (spi_op == OP_LOAD)
        begin
            instr_sr <= {1'b0, READ_CMD, 2'b00, img_num, flash_page, 7'b000_0000};
        end
        else if (start_op && spi_op == OP_SHIFT)
        begin
            instr_sr <= {instr_sr[31:0], 1'b0};   // next bit on falling sck
        end

        if (low_phase && sample_pend)
        begin
            bit_data <= miso;   // captured with the rising sck
        end
    end

endmodule

`default_nettype wire

//--- verilog/spi_loader_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module spi_loader_ctrl
#(
    parameter int BOOT_BITS = 2656,
    parameter int MAP_BITS  = 1168,
    parameter int PAGE_BITS = 512
)
(
    input  wire                       MCLK,
    input  wire                       rst_n,
    input  var bubble_pkg::acc_type_e acc_type,
    input  wire  [11:0]               page,
    input  wire                       bit_data,
    input  wire                       op_done,
    input  wire                       map_rdata,
    output logic                      conv_start,
    output bubble_pkg::spi_op_e       spi_op,
    output logic                      cs_sel,
    output logic [11:0]               flash_page,
    output logic                      map_wr,
    output logic [11:0]               map_waddr,
    output logic                      map_wdata,
    output logic                      map_rd,
    output logic [11:0]               map_raddr,
    output bubble_pkg::buf_wr_t       buf_wr
);
    import bubble_pkg::*;

    typedef enum logic [3:0] {
        IDLE, CONVERT, LOAD_CMD, SEND_CMD, BOOT_DATA,
        MAP_DATA, PAGE_MAP_READ, PAGE_DATA, PAGE_WRITE, FINISH
    } state_e;

    localparam logic [11:0] BOOT_N = 12'(BOOT_BITS);
    localparam logic [11:0] MAP_N  = 12'(MAP_BITS);
    localparam logic [11:0] LEAD_N = 12'(LEAD_BITS);
    localparam logic [11:0] GOOD_N = 12'(LEAD_BITS + PAGE_BITS);

    state_e      state;
    state_e      state_nx;
    logic        is_boot;
    logic        busy;        // reader op in flight
    logic        ready;
    logic [11:0] cnt;         // instruction bits, data bits or good loops
    logic        cnt_clr;
    logic        cnt_inc;
    logic        ptr_load;
    logic [11:0] map_addr;
    logic [14:0] buf_ptr;
    logic        wr_now;
    logic        wr_bit;
    logic        wr_strobe;
    logic [14:0] wr_addr;
    logic        wr_data;

    assign ready      = !busy || op_done;
    assign conv_start = (state == CONVERT);
    assign cs_sel     = !(state == IDLE || state == CONVERT || state == FINISH);
    assign flash_page = is_boot ? BOOT_PAGE : page;
    assign map_waddr  = map_addr;
    assign map_raddr  = map_addr;
    assign map_wdata  = bit_data;
    assign buf_wr     = '{strobe: wr_strobe, addr: wr_addr, data: wr_data};

    always_comb
    begin
        state_nx = state;
        spi_op   = OP_NONE;
        cnt_clr  = 1'b0;
        cnt_inc  = 1'b0;
        ptr_load = 1'b0;
        wr_now   = 1'b0;
        wr_bit   = bit_data;
        map_wr   = 1'b0;
        map_rd   = 1'b0;
        case (state)
            IDLE:
                if (acc_type != ACC_IDLE)
                    state_nx = CONVERT;
            CONVERT:
                state_nx = LOAD_CMD;   // page valid next cycle
            LOAD_CMD:
            begin
                spi_op   = OP_LOAD;
                cnt_clr  = 1'b1;
                state_nx = SEND_CMD;
            end
            SEND_CMD:
                if (ready)
                begin
                    if (cnt == 12'd32)
                    begin
                        cnt_clr  = 1'b1;
                        ptr_load = 1'b1;
                        state_nx = is_boot ? BOOT_DATA : PAGE_MAP_READ;
                    end
                    else
                    begin
                        spi_op  = OP_SHIFT;
                        cnt_inc = 1'b1;
                    end
                end
            BOOT_DATA, MAP_DATA:
            begin
                wr_now = op_done;
                map_wr = op_done && (state == MAP_DATA);
                if (ready)
                begin
                    if (cnt == ((state == BOOT_DATA) ? BOOT_N : MAP_N))
                    begin
                        cnt_clr  = 1'b1;
                        state_nx = (state == BOOT_DATA) ? MAP_DATA : FINISH;
                    end
                    else
                    begin
                        spi_op  = OP_SAMPLE;
                        cnt_inc = 1'b1;
                    end
                end
            end
            PAGE_MAP_READ:
                if (cnt == GOOD_N)
                    state_nx = FINISH;
                else
                begin
                    map_rd   = 1'b1;
                    state_nx = PAGE_DATA;
                end
            PAGE_DATA:
                if (!map_rdata)
                begin
                    wr_now   = 1'b1;   // bad loop
                    wr_bit   = 1'b0;
                    state_nx = PAGE_MAP_READ;
                end
                else if (cnt < LEAD_N)
                begin
                    wr_now   = 1'b1;   // lead loop
                    wr_bit   = 1'b1;
                    cnt_inc  = 1'b1;
                    state_nx = PAGE_MAP_READ;
                end
                else
                begin
                    spi_op   = OP_SAMPLE;
                    state_nx = PAGE_WRITE;
                end
            PAGE_WRITE:
                if (op_done)
                begin
                    wr_now   = 1'b1;
                    cnt_inc  = 1'b1;
                    state_nx = PAGE_MAP_READ;
                end
            FINISH:
                state_nx = IDLE;   // cs_n goes high next cycle
            default:
                state_nx = IDLE;
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            is_boot   <= 1'b0;
            busy      <= 1'b0;
            cnt       <= '0;
            wr_strobe <= 1'b0;
        end
        else
        begin
            state     <= state_nx;
            wr_strobe <= wr_now;
            if (state == IDLE)
                is_boot <= (acc_type == ACC_BOOT);
            if (spi_op == OP_SHIFT || spi_op == OP_SAMPLE)
                busy <= 1'b1;
            else if (op_done)
                busy <= 1'b0;
            if (cnt_clr)
                cnt <= '0;
            else if (cnt_inc)
                cnt <= cnt + 12'd1;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (ptr_load)
        begin
            buf_ptr  <= is_boot ? BOOT_BASE : PAGE_BASE;
            map_addr <= '0;
        end
        else
        begin
            if (wr_now)
                buf_ptr <= buf_ptr + 15'd1;
            if (map_wr || map_rd)
                map_addr <= map_addr + 12'd1;
        end
        if (wr_now)
        begin
            wr_addr <= buf_ptr;
            wr_data <= wr_bit;
        end
    end

endmodule

`default_nettype wire
